/* logic/synapse_pkg.sv */
`default_nettype none

package synapse_pkg;

    // datapath and instruction word width
    localparam int word_w = 16;

    // register file, top entry is the external i/o port
    localparam int reg_count = 16;
    localparam int io_reg = 15;
    localparam int reg_idx_w = $clog2(reg_count);

    // trace buffer sizing, depth kept a power of two
    localparam int trace_depth = 8;
    localparam int trace_aw = $clog2(trace_depth);

    // undefined codes fall through as nop
    typedef enum logic [3:0] {
        op_nop = 4'h0,
        op_ldi = 4'h1,
        op_add = 4'h2,
        op_sub = 4'h3,
        op_xor = 4'h4,
        op_jmp = 4'h5
    } opcode_t;

    // three-register form
    typedef struct packed {
        opcode_t opcode;
        logic [reg_idx_w-1:0] dst;
        logic [reg_idx_w-1:0] src_a;
        logic [reg_idx_w-1:0] src_b;
    } instr_reg_t;

    // immediate form, imm overlays src_a and src_b
    typedef struct packed {
        opcode_t opcode;
        logic [reg_idx_w-1:0] dst;
        logic [7:0] imm;
    } instr_imm_t;

    typedef union packed {
        instr_reg_t r_view;
        instr_imm_t i_view;
    } instr_t;

    // one register write as seen by the debugger
    typedef struct packed {
        logic [word_w-1:0] pc;
        logic [word_w-1:0] data;
    } trace_rec_t;

endpackage

`default_nettype wire

/* logic/trace_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface trace_if;

    import synapse_pkg::*;

    logic push;
    logic full;
    logic pop;
    logic empty;
    // record in on the write side, fifo head on the read side
    trace_rec_t rec;

    modport producer (output push, output rec, input full);
    modport buffer_wr (input push, input rec, output full);
    modport buffer_rd (input pop, output empty, output rec);
    modport consumer (output pop, input empty, input rec);

endinterface

`default_nettype wire

/* logic/synapse316_core.sv */
`timescale 1ns/1ps
`default_nettype none

module synapse316_core (
    input  wire                             sysclk,
    input  wire                             rst_n,
    output logic [synapse_pkg::word_w-1:0]  code_addr,
    input  wire synapse_pkg::instr_t        code_in,
    input  wire                             code_ready,
    input  wire [synapse_pkg::word_w-1:0]   io_in,
    output logic                            io_read,
    output logic                            io_load,
    output logic [synapse_pkg::word_w-1:0]  io_load_data,
    trace_if.producer                       trace
);

    import synapse_pkg::*;

    // general registers only, r15 lives outside as io_in / io_load
    logic [word_w-1:0] rf [reg_count-1];
    logic [word_w-1:0] pc;

    opcode_t op;
    logic [reg_idx_w-1:0] dst;
    logic [reg_idx_w-1:0] src_a;
    logic [reg_idx_w-1:0] src_b;
    logic [7:0] imm;

    logic is_alu;
    logic writes;
    logic exec;
    logic rd_io;
    logic wr_io;
    logic [word_w-1:0] a_val;
    logic [word_w-1:0] b_val;
    logic [word_w-1:0] result;

    // same word, two views
    // register fields from the reg view, immediate from the imm view
    assign op = code_in.r_view.opcode;
    assign dst = code_in.r_view.dst;
    assign src_a = code_in.r_view.src_a;
    assign src_b = code_in.r_view.src_b;
    assign imm = code_in.i_view.imm;

    assign is_alu = (op == op_add) || (op == op_sub) || (op == op_xor);
    assign writes = is_alu || (op == op_ldi);

    // one instruction per edge with code present and room for its trace
    assign exec = code_ready && !trace.full;

    // source read, r15 maps to the external port
    assign a_val = (src_a == io_reg) ? io_in : rf[src_a];
    assign b_val = (src_b == io_reg) ? io_in : rf[src_b];

    // only alu ops read sources, ldi bits there are immediate
    assign rd_io = is_alu && ((src_a == io_reg) || (src_b == io_reg));
    assign wr_io = writes && (dst == io_reg);

    always_comb begin
        case (op)
            op_ldi:  result = word_w'(imm);
            op_add:  result = a_val + b_val;
            op_sub:  result = a_val - b_val;
            op_xor:  result = a_val ^ b_val;
            default: result = '0;
        endcase
    end

    // pc and i/o strobes
    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= '0;
            io_read <= 1'b0;
            io_load <= 1'b0;
        end else begin
            // strobes mark the edge that executed
            io_read <= exec && rd_io;
            io_load <= exec && wr_io;
            if (exec) begin
                if (op == op_jmp) begin
                    pc <= word_w'(imm);
                end else begin
                    pc <= pc + 1'b1;
                end
            end
        end
    end

    // register file and i/o payload
    always_ff @(posedge sysclk) begin
        if (exec && writes) begin
            if (dst == io_reg) begin
                io_load_data <= result;
            end else begin
                rf[dst] <= result;
            end
        end
    end

    assign code_addr = pc;

    // one trace record per register write, tagged with its own pc
    assign trace.push = exec && writes;
    assign trace.rec.pc = pc;
    assign trace.rec.data = result;

endmodule

`default_nettype wire

/* logic/trace_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module trace_fifo (
    input  wire         sysclk,
    input  wire         rst_n,
    trace_if.buffer_wr  wr,
    trace_if.buffer_rd  rd
);

    import synapse_pkg::*;

    trace_rec_t mem [trace_depth];
    logic [trace_aw-1:0] wr_ptr;
    logic [trace_aw-1:0] rd_ptr;
    // one extra bit to tell full from empty
    logic [trace_aw:0] count;
    logic do_push;
    logic do_pop;

    assign do_push = wr.push && !wr.full;
    assign do_pop = rd.pop && !rd.empty;

    assign wr.full = (count == (trace_aw + 1)'(trace_depth));
    assign rd.empty = (count == '0);
    // head shows right after the pushing edge
    assign rd.rec = mem[rd_ptr];

    // pointers wrap on their own, depth is a power of two
    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge sysclk) begin
        if (do_push) begin
            mem[wr_ptr] <= wr.rec;
        end
    end

    // neither side may lean on the guards above
    a_no_overrun: assert property (
        @(posedge sysclk) disable iff (!rst_n)
        !(wr.push && wr.full) && !(rd.pop && rd.empty)
    );

endmodule

`default_nettype wire

/* logic/debug_visor.sv */
`timescale 1ns/1ps
`default_nettype none

module debug_visor (
    input  wire                             sysclk,
    input  wire                             rst_n,
    input  wire                             mcu_wait,
    input  wire                             code_ready,
    output logic                            core_code_ready,
    trace_if.consumer                       trace,
    output logic [synapse_pkg::word_w-1:0]  av_address,
    input  wire                             av_waitrequest,
    output logic [synapse_pkg::word_w-1:0]  av_writedata,
    output logic                            av_write
);

    // output register is idle or its write retires this edge
    logic slot_free;

    // mcu_wait freezes the core by hiding code
    assign core_code_ready = code_ready && !mcu_wait;

    assign slot_free = !av_write || !av_waitrequest;

    // refill on the completing edge, so writes can run back to back
    assign trace.pop = !trace.empty && slot_free;

    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            av_write <= 1'b0;
        end else if (trace.pop) begin
            av_write <= 1'b1;
        end else if (!av_waitrequest) begin
            // accepted and nothing behind it
            av_write <= 1'b0;
        end
    end

    // address is the pc, data the written value
    always_ff @(posedge sysclk) begin
        if (trace.pop) begin
            av_address <= trace.rec.pc;
            av_writedata <= trace.rec.data;
        end
    end

    // a stalled request must not move
    a_av_hold: assert property (
        @(posedge sysclk) disable iff (!rst_n)
        av_write && av_waitrequest |=>
            av_write && $stable(av_address) && $stable(av_writedata)
    );

endmodule

`default_nettype wire

/* logic/supervised_synapse316.sv */
`timescale 1ns/1ps
`default_nettype none

module supervised_synapse316 (
    input  wire                             sysclk,
    input  wire                             rst_n,
    input  wire                             mcu_wait,
    // code memory
    output wire [synapse_pkg::word_w-1:0]   code_addr,
    input  wire [synapse_pkg::word_w-1:0]   code_in,
    input  wire                             code_ready,
    // external register 15
    input  wire [synapse_pkg::word_w-1:0]   io_in,
    output wire                             io_read,
    output wire                             io_load,
    output wire [synapse_pkg::word_w-1:0]   io_load_data,
    // avalon-mm master for the trace
    output wire [synapse_pkg::word_w-1:0]   dbg_av_address,
    input  wire                             dbg_av_waitrequest,
    output wire [synapse_pkg::word_w-1:0]   dbg_av_writedata,
    output wire                             dbg_av_write
);

    // gated by the supervisor
    wire core_code_ready;

    // core side and supervisor side of the trace fifo
    trace_if core_trace ();
    trace_if visor_trace ();

    synapse316_core core (
        .sysclk       (sysclk),
        .rst_n        (rst_n),
        .code_addr    (code_addr),
        .code_in      (code_in),
        .code_ready   (core_code_ready),
        .io_in        (io_in),
        .io_read      (io_read),
        .io_load      (io_load),
        .io_load_data (io_load_data),
        .trace        (core_trace)
    );

    trace_fifo fifo (
        .sysclk (sysclk),
        .rst_n  (rst_n),
        .wr     (core_trace),
        .rd     (visor_trace)
    );

    debug_visor visor (
        .sysclk          (sysclk),
        .rst_n           (rst_n),
        .mcu_wait        (mcu_wait),
        .code_ready      (code_ready),
        .core_code_ready (core_code_ready),
        .trace           (visor_trace),
        .av_address      (dbg_av_address),
        .av_waitrequest  (dbg_av_waitrequest),
        .av_writedata    (dbg_av_writedata),
        .av_write        (dbg_av_write)
    );

endmodule

`default_nettype wire

/* verification/supervised_synapse316_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module supervised_synapse316_tb;

    import synapse_pkg::*;

    localparam int prog_words = 256;
    localparam int run_cycles = 4000;
    localparam int drain_limit = 2000;

    logic sysclk;
    logic rst_n;
    logic mcu_wait;
    logic [15:0] code_in;
    logic code_ready;
    logic [15:0] io_in;
    logic dbg_av_waitrequest;
    wire [15:0] code_addr;
    wire io_read;
    wire io_load;
    wire [15:0] io_load_data;
    wire [15:0] dbg_av_address;
    wire [15:0] dbg_av_writedata;
    wire dbg_av_write;

    logic [31:0] seed;
    logic [15:0] prog [prog_words];
    // reference model state, entry 15 unused
    logic [15:0] m_regs [16];
    logic [15:0] m_pc;
    // expected avalon writes as {pc, data}
    logic [31:0] exp_writes [$];
    logic exp_load;
    logic [15:0] exp_load_data;
    logic exp_read;
    logic hold_seen;
    logic [15:0] held_addr;
    logic [15:0] held_data;
    int wait_left;
    int stall_left;
    int err_count;
    int writes_done;

    supervised_synapse316 uut (
        .sysclk             (sysclk),
        .rst_n              (rst_n),
        .mcu_wait           (mcu_wait),
        .code_addr          (code_addr),
        .code_in            (code_in),
        .code_ready         (code_ready),
        .io_in              (io_in),
        .io_read            (io_read),
        .io_load            (io_load),
        .io_load_data       (io_load_data),
        .dbg_av_address     (dbg_av_address),
        .dbg_av_waitrequest (dbg_av_waitrequest),
        .dbg_av_writedata   (dbg_av_writedata),
        .dbg_av_write       (dbg_av_write)
    );

    initial begin
        sysclk = 1'b0;
        forever #5 sysclk = ~sysclk;
    end

    // lcg step, upper half only since the low bits cycle fast
    function automatic logic [15:0] rand16();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed[31:16];
    endfunction

    task automatic report_mismatch(input string name, input logic [15:0] got,
                                   input logic [15:0] exp);
        err_count++;
        $display("mismatch at time %0t: %s got %h expected %h", $time, name, got, exp);
    endtask

    task automatic report_failure(input string what);
        err_count++;
        $display("error at time %0t: %s", $time, what);
    endtask

    // first 15 words load r0..r14, so the model never reads an unset register
    task automatic build_program();
        logic [15:0] r;
        logic [15:0] f;
        logic [3:0] op;
        logic last_jmp;
        last_jmp = 1'b0;
        for (int a = 0; a < prog_words; a++) begin
            r = rand16();
            f = rand16();
            if (a < 15) begin
                prog[a] = {op_ldi, a[3:0], f[7:0]};
            end else begin
                case (r[15:13])
                    3'd0: op = op_ldi;
                    3'd1: op = op_add;
                    3'd2: op = op_sub;
                    3'd3: op = op_xor;
                    3'd4: op = op_jmp;
                    3'd5: op = op_nop;
                    3'd6: op = 4'hc;
                    default: op = op_add;
                endcase
                // no jmp after jmp and no jmp onto itself
                if (op == op_jmp && (last_jmp || f[7:0] == a[7:0])) begin
                    op = op_xor;
                end
                prog[a] = {op, f[11:0]};
                last_jmp = (op == op_jmp);
            end
        end
    endtask

    // answer the fetch, then randomize or quiet the other inputs
    task automatic drive_inputs(input logic randomize);
        logic [15:0] r;
        code_in = prog[code_addr[7:0]];
        if (!randomize) begin
            code_ready = 1'b0;
            mcu_wait = 1'b0;
            dbg_av_waitrequest = 1'b0;
        end else begin
            r = rand16();
            code_ready = (r[15:12] != 4'h0);
            if (wait_left > 0) begin
                mcu_wait = 1'b1;
                wait_left--;
            end else begin
                mcu_wait = 1'b0;
                if (r[11:7] == 5'd0) wait_left = 2 + int'(r[3:0]);
            end
            r = rand16();
            // long waitrequest bursts push the fifo to full
            if (stall_left > 0) begin
                dbg_av_waitrequest = 1'b1;
                stall_left--;
            end else if (r[15:11] == 5'd0) begin
                dbg_av_waitrequest = 1'b1;
                stall_left = 10 + int'(r[4:0]);
            end else begin
                dbg_av_waitrequest = r[9] & r[8];
            end
            io_in = rand16();
        end
    endtask

    // checks and model run mid-cycle, inputs and fifo level are stable here
    always @(negedge sysclk) begin : model
        logic [15:0] word;
        logic [3:0] op;
        logic [3:0] dst;
        logic [3:0] sa;
        logic [3:0] sb;
        logic [15:0] a_val;
        logic [15:0] b_val;
        logic [15:0] result;
        logic [31:0] head;
        logic is_alu;
        if (rst_n) begin
            assert (code_addr == m_pc)
                else report_mismatch("code_addr", code_addr, m_pc);
            // strobes of the edge just past
            assert (io_load == exp_load)
                else report_mismatch("io_load", 16'(io_load), 16'(exp_load));
            assert (io_read == exp_read)
                else report_mismatch("io_read", 16'(io_read), 16'(exp_read));
            if (exp_load) begin
                assert (io_load_data == exp_load_data)
                    else report_mismatch("io_load_data", io_load_data, exp_load_data);
            end
            // request stalled last cycle must still be there unchanged
            if (hold_seen) begin
                assert (dbg_av_write)
                    else report_failure("av_write dropped while waitrequest was high");
                assert (dbg_av_address == held_addr)
                    else report_mismatch("dbg_av_address", dbg_av_address, held_addr);
                assert (dbg_av_writedata == held_data)
                    else report_mismatch("dbg_av_writedata", dbg_av_writedata, held_data);
            end
            hold_seen = dbg_av_write && dbg_av_waitrequest;
            held_addr = dbg_av_address;
            held_data = dbg_av_writedata;
            // write completes on the coming edge
            if (dbg_av_write && !dbg_av_waitrequest) begin
                if (exp_writes.size() == 0) begin
                    report_failure("avalon write completed with none expected");
                end else begin
                    head = exp_writes.pop_front();
                    writes_done++;
                    assert (dbg_av_address == head[31:16])
                        else report_mismatch("dbg_av_address", dbg_av_address, head[31:16]);
                    assert (dbg_av_writedata == head[15:0])
                        else report_mismatch("dbg_av_writedata", dbg_av_writedata, head[15:0]);
                end
            end
            exp_load = 1'b0;
            exp_read = 1'b0;
            // instruction taken on the coming edge
            if (code_ready && !mcu_wait && !uut.core_trace.full) begin
                word = prog[m_pc[7:0]];
                op = word[15:12];
                dst = word[11:8];
                sa = word[7:4];
                sb = word[3:0];
                a_val = (sa == 4'hf) ? io_in : m_regs[sa];
                b_val = (sb == 4'hf) ? io_in : m_regs[sb];
                is_alu = (op == op_add) || (op == op_sub) || (op == op_xor);
                exp_read = is_alu && (sa == 4'hf || sb == 4'hf);
                case (op)
                    op_ldi: result = {8'h00, word[7:0]};
                    op_add: result = a_val + b_val;
                    op_sub: result = a_val - b_val;
                    op_xor: result = a_val ^ b_val;
                    default: result = 16'h0000;
                endcase
                if (is_alu || op == op_ldi) begin
                    if (dst == 4'hf) begin
                        exp_load = 1'b1;
                        exp_load_data = result;
                    end else begin
                        m_regs[dst] = result;
                    end
                    exp_writes.push_back({m_pc, result});
                end
                m_pc = (op == op_jmp) ? {8'h00, word[7:0]} : m_pc + 16'd1;
            end
        end
    end

    initial begin
        int cycles;
        seed = 32'he3e4_3142;
        err_count = 0;
        writes_done = 0;
        wait_left = 0;
        stall_left = 0;
        m_pc = 16'h0000;
        exp_load = 1'b0;
        exp_read = 1'b0;
        hold_seen = 1'b0;
        rst_n = 1'b0;
        mcu_wait = 1'b0;
        code_in = 16'h0000;
        code_ready = 1'b0;
        io_in = 16'h0000;
        dbg_av_waitrequest = 1'b0;
        build_program();
        repeat (5) @(posedge sysclk);
        assert (!dbg_av_write && !io_load && !io_read && code_addr == 16'h0000)
            else report_failure("outputs not idle with reset held");
        #1;
        rst_n = 1'b1;
        drive_inputs(1'b1);
        for (int c = 0; c < run_cycles; c++) begin
            @(posedge sysclk);
            #1;
            drive_inputs(1'b1);
        end
        // stop fetching and let the trace drain
        cycles = 0;
        while ((exp_writes.size() != 0 || dbg_av_write) && cycles < drain_limit) begin
            @(posedge sysclk);
            #1;
            drive_inputs(1'b0);
            cycles++;
        end
        if (cycles >= drain_limit) begin
            report_failure("trace writes did not drain before the timeout");
        end
        if (writes_done == 0) begin
            report_failure("no avalon write completed during the run");
        end
        $display("run finished: %0d writes checked, %0d errors", writes_done, err_count);
        if (err_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
logic/synapse_pkg.sv
logic/trace_if.sv
logic/synapse316_core.sv
logic/trace_fifo.sv
logic/debug_visor.sv
logic/supervised_synapse316.sv
verification/supervised_synapse316_tb.sv

/* Makefile */
# verilator flow for the supervised synapse316 testbench
# any variable below can be overridden, e.g. make sim LOG=run.log

VERILATOR ?= verilator
TOP       ?= supervised_synapse316_tb
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
PASS_MSG  ?= NO ERRORS

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# pass only if the log holds the pass line on its own
sim: build
	-./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }
	@echo "simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
